//--- rtl/alu_addsub.sv
// #########################################################
// element width aware adder and subtracter
// eight bit slices, carry passed on only inside 16 or 32
// bit elements, sub uses inverted vs1 plus carry-in of one
// #########################################################

`timescale 1ns/1ps

module alu_addsub import alu_pkg::*; (
  input  logic [VLEN-1:0] vs2,
  input  logic [VLEN-1:0] vs1,
  input  sew_e            sew,
  input  logic            sub,
  output logic [VLEN-1:0] sum
);

  localparam int NSLICE = VLEN / 8;

  // second operand after the sub inversion
  logic [VLEN-1:0]   op2;
  logic [NSLICE-1:0] carry_in;
  logic [NSLICE-1:0] carry_out;

  assign op2 = sub ? ~vs1 : vs1;

  for (genvar s = 0; s < NSLICE; s++) begin : g_slice
    if (s == 0) begin : g_first
      assign carry_in[s] = sub;
    end else begin : g_rest
      // boundary below slice s lies inside an element
      logic chain;

      assign chain = ((sew == sew_16) && (s % 2 != 0)) ||
                     ((sew == sew_32) && (s % 4 != 0));
      // element start gets the add/sub seed instead
      assign carry_in[s] = chain ? carry_out[s-1] : sub;
    end

    // 8-bit slice adder, carry-out kept for the next slice
    assign {carry_out[s], sum[s*8 +: 8]} =
      {1'b0, vs2[s*8 +: 8]} + {1'b0, op2[s*8 +: 8]} + 9'(carry_in[s]);
  end

endmodule

//--- rtl/alu_cluster.sv
// #########################################################
// vector integer alu cluster top
// reservation station queue feeding NUM_ALU lanes, each
// with its own result port toward the reorder buffer
// #########################################################

`timescale 1ns/1ps

module alu_cluster import alu_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           push_valid,
  input  alu_uop_t                       push_uop,
  output logic                           push_ready,
  output logic        [NUM_ALU-1:0]      result_valid,
  output alu_result_t [NUM_ALU-1:0]      result,
  input  logic        [NUM_ALU-1:0]      result_ready
);

  // queue to dispatch
  alu_uop_t [NUM_ALU-1:0] rs_uops;
  logic                   rs_empty;
  logic     [NUM_ALU-1:1] rs_almost_empty;
  logic     [NUM_ALU-1:0] pop;

  alu_rs_fifo u_rs_fifo (
    .clk             (clk),
    .reset           (reset),
    .push_valid      (push_valid),
    .push_uop        (push_uop),
    .push_ready      (push_ready),
    .rs_uops         (rs_uops),
    .rs_empty        (rs_empty),
    .rs_almost_empty (rs_almost_empty),
    .pop             (pop)
  );

  alu_dispatch u_dispatch (
    .clk             (clk),
    .reset           (reset),
    .rs_uops         (rs_uops),
    .rs_empty        (rs_empty),
    .rs_almost_empty (rs_almost_empty),
    .pop             (pop),
    .result_valid    (result_valid),
    .result          (result),
    .result_ready    (result_ready)
  );

endmodule

//--- rtl/alu_dispatch.sv
// #########################################################
// alu dispatch
// turns queue flags into slot valids, pops the oldest
// entries in order into the lanes that can take them
// #########################################################

`timescale 1ns/1ps

module alu_dispatch import alu_pkg::*; (
  input  logic                           clk,
  input  logic                           reset,
  input  alu_uop_t    [NUM_ALU-1:0]      rs_uops,
  input  logic                           rs_empty,
  input  logic        [NUM_ALU-1:1]      rs_almost_empty,
  output logic        [NUM_ALU-1:0]      pop,
  output logic        [NUM_ALU-1:0]      result_valid,
  output alu_result_t [NUM_ALU-1:0]      result,
  input  logic        [NUM_ALU-1:0]      result_ready
);

  logic [NUM_ALU-1:0] slot_valid;
  logic [NUM_ALU-1:0] accept;

  // oldest entry is there whenever the queue is not empty
  assign slot_valid[0] = !rs_empty;
  assign pop[0]        = slot_valid[0] & accept[0];

  // younger slots need enough entries and every older slot popped
  for (genvar i = 1; i < NUM_ALU; i++) begin : g_slot
    assign slot_valid[i] = !(rs_empty || (|rs_almost_empty[i:1]));
    assign pop[i]        = slot_valid[i] & accept[i] & (&pop[i-1:0]);
  end

  // lanes take the entry in the same cycle it leaves the queue
  for (genvar i = 0; i < NUM_ALU; i++) begin : g_unit
    alu_unit u_alu_unit (
      .clk          (clk),
      .reset        (reset),
      .uop_valid    (pop[i]),
      .uop          (rs_uops[i]),
      .accept       (accept[i]),
      .result_valid (result_valid[i]),
      .result       (result[i]),
      .result_ready (result_ready[i])
    );
  end

endmodule

//--- rtl/alu_pkg.sv
// #########################################################
// vector integer alu cluster shared definitions
// widths, lane and queue sizes, op and element width codes,
// micro-op and result records passed between the blocks
// #########################################################

package alu_pkg;

  // vector register width in bits
  localparam int VLEN = 64;

  // number of identical alu lanes
  localparam int NUM_ALU = 2;

  // reservation station entries
  localparam int RS_DEPTH = 8;

  // reorder buffer tag width
  localparam int ROB_IDX_W = 4;

  // alu operation codes
  typedef enum logic [2:0] {
    op_add = 3'd0,
    op_sub = 3'd1,
    op_sll = 3'd2,
    op_srl = 3'd3,
    op_sra = 3'd4,
    op_and = 3'd5,
    op_or  = 3'd6,
    op_xor = 3'd7
  } alu_op_e;

  // element width, code 3 unused
  typedef enum logic [1:0] {
    sew_8  = 2'd0,
    sew_16 = 2'd1,
    sew_32 = 2'd2
  } sew_e;

  // micro-op held in the reservation station
  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    alu_op_e              op;
    sew_e                 sew;
    logic [VLEN-1:0]      vs2_data;
    logic [VLEN-1:0]      vs1_data;
  } alu_uop_t;

  // result written back to the reorder buffer
  typedef struct packed {
    logic [ROB_IDX_W-1:0] rob_idx;
    logic [VLEN-1:0]      vd_data;
  } alu_result_t;

endpackage

//--- rtl/alu_rs_fifo.sv
// #########################################################
// alu reservation station queue
// one push port, in-order pop of up to NUM_ALU entries,
// head window of the oldest entries plus empty and
// almost-empty flags for each dispatch slot
// #########################################################

`timescale 1ns/1ps

module alu_rs_fifo import alu_pkg::*; (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         push_valid,
  input  alu_uop_t                     push_uop,
  output logic                         push_ready,
  output alu_uop_t [NUM_ALU-1:0]       rs_uops,
  output logic                         rs_empty,
  output logic     [NUM_ALU-1:1]       rs_almost_empty,
  input  logic     [NUM_ALU-1:0]       pop
);

  // pointer and occupancy widths
  localparam int PTR_W = $clog2(RS_DEPTH);
  localparam int CNT_W = $clog2(RS_DEPTH + 1);

  // entry storage
  alu_uop_t             mem [RS_DEPTH];

  logic [PTR_W-1:0]     rd_ptr;
  logic [PTR_W-1:0]     wr_ptr;
  logic [CNT_W-1:0]     count;
  logic [CNT_W-1:0]     pop_cnt;
  logic                 push_fire;

  // room left in the queue
  assign push_ready = (count < CNT_W'(RS_DEPTH));
  assign push_fire  = push_valid & push_ready;

  // pop bits form a run from bit 0, so the sum is the run length
  always_comb begin
    pop_cnt = '0;
    for (int i = 0; i < NUM_ALU; i++) begin
      pop_cnt = pop_cnt + CNT_W'(pop[i]);
    end
  end

  // pointers and count
  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= '0;
      wr_ptr <= '0;
      count  <= '0;
    end else begin
      if (push_fire) begin
        wr_ptr <= wr_ptr + PTR_W'(1);
      end
      rd_ptr <= rd_ptr + PTR_W'(pop_cnt);
      count  <= count + CNT_W'(push_fire) - pop_cnt;
    end
  end

  // payload write
  always_ff @(posedge clk) begin
    if (push_fire) begin
      mem[wr_ptr] <= push_uop;
    end
  end

  // head window, wraps from the read pointer
  for (genvar i = 0; i < NUM_ALU; i++) begin : g_head
    assign rs_uops[i] = mem[rd_ptr + PTR_W'(i)];
  end

  assign rs_empty = (count == '0);

  // slot i has nothing when at most i entries are held
  for (genvar i = 1; i < NUM_ALU; i++) begin : g_aempty
    assign rs_almost_empty[i] = (count <= CNT_W'(i));
  end

endmodule

//--- rtl/alu_shift.sv
// #########################################################
// per element vector shifter
// left shift on its own, logical and arithmetic right
// shift share one arithmetic shifter with a chosen fill bit
// #########################################################

`timescale 1ns/1ps

module alu_shift import alu_pkg::*; (
  input  logic [VLEN-1:0] vs2,
  input  logic [VLEN-1:0] vs1,
  input  sew_e            sew,
  input  alu_op_e         op,
  output logic [VLEN-1:0] shifted
);

  // results for 8, 16 and 32 bit elements
  logic [2:0][VLEN-1:0] sll_res;
  logic [2:0][VLEN-1:0] sr_res;

  for (genvar w = 0; w < 3; w++) begin : g_width
    localparam int EW   = 8 << w;
    localparam int SH_W = 3 + w;

    for (genvar e = 0; e < VLEN / EW; e++) begin : g_elem
      logic [EW-1:0]   src;
      logic [SH_W-1:0] amt;
      logic            fill;
      logic [EW:0]     sra_ext;

      assign src  = vs2[e*EW +: EW];
      // shift amount modulo the element width
      assign amt  = vs1[e*EW +: SH_W];
      // sign fill only for sra, zero for srl
      assign fill = (op == op_sra) & src[EW-1];

      assign sll_res[w][e*EW +: EW] = src << amt;
      assign sra_ext = $signed({fill, src}) >>> amt;
      assign sr_res[w][e*EW +: EW]  = sra_ext[EW-1:0];
    end
  end

  always_comb begin
    case (sew)
      sew_8:   shifted = (op == op_sll) ? sll_res[0] : sr_res[0];
      sew_16:  shifted = (op == op_sll) ? sll_res[1] : sr_res[1];
      sew_32:  shifted = (op == op_sll) ? sll_res[2] : sr_res[2];
      default: shifted = '0;
    endcase
  end

endmodule

//--- rtl/alu_unit.sv
// #########################################################
// single alu lane
// decodes one micro-op, picks addsub, shift or bitwise
// logic and holds the result until the reorder buffer
// takes it on its valid/ready port
// #########################################################

`timescale 1ns/1ps

module alu_unit import alu_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  logic        uop_valid,
  input  alu_uop_t    uop,
  output logic        accept,
  output logic        result_valid,
  output alu_result_t result,
  input  logic        result_ready
);

  logic [VLEN-1:0] sum;
  logic [VLEN-1:0] shifted;
  logic [VLEN-1:0] vd_next;

  // add and sub share the slice adder
  alu_addsub u_addsub (
    .vs2 (uop.vs2_data),
    .vs1 (uop.vs1_data),
    .sew (uop.sew),
    .sub (uop.op == op_sub),
    .sum (sum)
  );

  alu_shift u_shift (
    .vs2     (uop.vs2_data),
    .vs1     (uop.vs1_data),
    .sew     (uop.sew),
    .op      (uop.op),
    .shifted (shifted)
  );

  // result select, bitwise ops need no element split
  always_comb begin
    case (uop.op)
      op_add, op_sub:         vd_next = sum;
      op_sll, op_srl, op_sra: vd_next = shifted;
      op_and:                 vd_next = uop.vs2_data & uop.vs1_data;
      op_or:                  vd_next = uop.vs2_data | uop.vs1_data;
      default:                vd_next = uop.vs2_data ^ uop.vs1_data;
    endcase
  end

  // register empty or being drained this cycle
  assign accept = !result_valid || result_ready;

  // output valid flag
  always_ff @(posedge clk) begin
    if (reset) begin
      result_valid <= 1'b0;
    end else if (uop_valid && accept) begin
      result_valid <= 1'b1;
    end else if (result_ready) begin
      result_valid <= 1'b0;
    end
  end

  // payload, stable while held
  always_ff @(posedge clk) begin
    if (uop_valid && accept) begin
      result.rob_idx <= uop.rob_idx;
      result.vd_data <= vd_next;
    end
  end

endmodule

//--- run.sh
#!/bin/sh
# build and run the alu cluster testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_alu_cluster -f sim.f -o tb_alu_cluster > build.log 2>&1
if [ $? -ne 0 ]; then
  echo "build failed, see build.log"
  exit 1
fi

./obj_dir/tb_alu_cluster > sim.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see sim.log"
  exit 1
fi

if grep -q "^TEST PASS$" sim.log; then
  echo "simulation passed"
  exit 0
fi
echo "simulation failed, see sim.log"
exit 1

//--- sim.f
rtl/alu_pkg.sv
rtl/alu_rs_fifo.sv
rtl/alu_addsub.sv
rtl/alu_shift.sv
rtl/alu_unit.sv
rtl/alu_dispatch.sv
rtl/alu_cluster.sv
test/tb_alu_cluster.sv

//--- test/tb_alu_cluster.sv
// ##########################################################
// testbench for the vector integer alu cluster
// random and directed micro-ops, reorder buffer model with
// random ready, reference model and result scoreboard
// ##########################################################

`timescale 1ns/1ps

module tb_alu_cluster import alu_pkg::*; ();

  localparam int N_DIR  = 24 + 12;
  // lane 0 holds one, NUM_ALU more wait behind it for the release
  localparam int N_PRE  = NUM_ALU + 1;
  localparam int N_FILL = N_PRE + RS_DEPTH;
  localparam int N_RAND = 200;
  localparam int N_PUSH = N_DIR + N_FILL + N_RAND;
  localparam int LIMIT  = N_PUSH * 4 + 200;

  logic                      clk;
  logic                      reset = 1'b1;
  logic                      push_valid = 1'b0;
  alu_uop_t                  push_uop = '0;
  logic                      push_ready;
  logic        [NUM_ALU-1:0] result_valid;
  alu_result_t [NUM_ALU-1:0] result;
  logic        [NUM_ALU-1:0] result_ready = '0;

  // scoreboard, indexed by rob tag
  logic [15:0]     busy = '0;
  logic [VLEN-1:0] exp_vd [16];
  int              seq [16];
  int              push_count = 0;
  int              recv_count = 0;
  logic [3:0]      next_tag = '0;
  integer          seed = 94;
  int              cycles = 0;
  // 0 random, 1 all low, 2 all high, 3 only lane 0 high
  int              ready_mode = 0;
  logic        [NUM_ALU-1:0] holding = '0;
  alu_result_t [NUM_ALU-1:0] held_res;

  alu_cluster dut (
    .clk          (clk),
    .reset        (reset),
    .push_valid   (push_valid),
    .push_uop     (push_uop),
    .push_ready   (push_ready),
    .result_valid (result_valid),
    .result       (result),
    .result_ready (result_ready)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  task automatic stop_on_error();
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // expected vd, element by element on zero extended values
  function automatic logic [VLEN-1:0] ref_vd(alu_op_e op, sew_e sew,
                                             logic [VLEN-1:0] a, logic [VLEN-1:0] b);
    int          ew;
    int          sh;
    logic [63:0] mask;
    logic [63:0] x;
    logic [63:0] y;
    logic [63:0] r;
    logic [63:0] res;
    ew   = 8 << sew;
    mask = (64'd1 << ew) - 64'd1;
    res  = '0;
    for (int e = 0; e < VLEN / ew; e++) begin
      x  = (a >> (e * ew)) & mask;
      y  = (b >> (e * ew)) & mask;
      // amount taken modulo the element width
      sh = int'(y % 64'(ew));
      case (op)
        op_add:  r = x + y;
        op_sub:  r = x - y;
        op_sll:  r = x << sh;
        op_srl:  r = x >> sh;
        op_sra:  r = (x >> sh) | (x[ew-1] ? (mask & ~(mask >> sh)) : 64'd0);
        op_and:  r = x & y;
        op_or:   r = x | y;
        default: r = x ^ y;
      endcase
      res = res | ((r & mask) << (e * ew));
    end
    return res;
  endfunction

  function automatic logic [VLEN-1:0] rand64();
    return {$random(seed), $random(seed)};
  endfunction

  // called at a falling edge, returns one falling edge after the push
  task automatic push_one(input alu_op_e op, input sew_e sew,
                          input logic [VLEN-1:0] a, input logic [VLEN-1:0] b);
    alu_uop_t u;
    while (busy[next_tag]) begin
      push_valid = 1'b0;
      @(negedge clk);
    end
    u.rob_idx  = next_tag;
    u.op       = op;
    u.sew      = sew;
    u.vs2_data = a;
    u.vs1_data = b;
    push_valid = 1'b1;
    push_uop   = u;
    while (!push_ready) @(negedge clk);
    busy[next_tag]   = 1'b1;
    exp_vd[next_tag] = ref_vd(op, sew, a, b);
    seq[next_tag]    = push_count;
    push_count++;
    next_tag++;
    @(negedge clk);
  endtask

  task automatic push_random();
    push_one(alu_op_e'(3'($random(seed))),
             sew_e'(2'(($random(seed) & 32'h7fff_ffff) % 3)), rand64(), rand64());
  endtask

  // reorder buffer ready
  always @(negedge clk) begin
    if (reset) begin
      result_ready = '0;
    end else begin
      for (int i = 0; i < NUM_ALU; i++) begin
        case (ready_mode)
          0:       result_ready[i] = (($random(seed) & 3) != 0);
          1:       result_ready[i] = 1'b0;
          3:       result_ready[i] = (i == 0);
          default: result_ready[i] = 1'b1;
        endcase
      end
    end
  end

  always @(posedge clk) begin : compare_results
    logic [3:0] tag;
    if (!reset) begin
      // same-cycle pops go to lane 0 with the older one
      assert (!(dut.pop[1] && !dut.pop[0])) else begin
        $display("lane 1 popped while lane 0 did not at %0t", $time);
        stop_on_error();
      end
      if (dut.pop[0] && dut.pop[1]) begin
        assert (seq[dut.rs_uops[0].rob_idx] < seq[dut.rs_uops[1].rob_idx]) else begin
          $display("lane 0 got a younger micro-op than lane 1 at %0t", $time);
          stop_on_error();
        end
      end
      for (int i = 0; i < NUM_ALU; i++) begin
        if (result_valid[i] && result_ready[i]) begin
          tag = result[i].rob_idx;
          assert (busy[tag]) else begin
            $display("rob_idx %0d returned on lane %0d but was not outstanding at %0t",
                     tag, i, $time);
            stop_on_error();
          end
          assert (result[i].vd_data === exp_vd[tag]) else begin
            $display("** Error at %0t: result[%0d].vd_data (rob_idx %0d) expected %h actual %h",
                     $time, i, tag, exp_vd[tag], result[i].vd_data);
            stop_on_error();
          end
          busy[tag] = 1'b0;
          recv_count++;
        end
        // held result must not move up to and including its transfer
        if (result_valid[i] && holding[i]) begin
          assert (result[i] === held_res[i]) else begin
            $display("** Error at %0t: result[%0d] held expected %h actual %h",
                     $time, i, held_res[i], result[i]);
            stop_on_error();
          end
        end
        if (result_valid[i] && !result_ready[i]) begin
          holding[i]  = 1'b1;
          held_res[i] = result[i];
        end else begin
          holding[i] = 1'b0;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles > LIMIT) begin
      $display("timeout after %0d cycles, %0d of %0d results received",
               cycles, recv_count, N_PUSH);
      stop_on_error();
    end
  end

  task automatic check_idle();
    assert (result_valid == '0) else begin
      $display("** Error at %0t: result_valid expected 0 actual %b", $time, result_valid);
      stop_on_error();
    end
    assert (push_ready === 1'b1) else begin
      $display("** Error at %0t: push_ready expected 1 actual %b", $time, push_ready);
      stop_on_error();
    end
  endtask

  initial begin
    for (int c = 0; c < 16; c++) begin
      @(negedge clk);
      if (c > 0) begin
        check_idle();
      end
    end
    reset = 1'b0;
    @(negedge clk);
    check_idle();

    // every op at every element width
    for (int o = 0; o < 8; o++) begin
      for (int w = 0; w < 3; w++) begin
        push_one(alu_op_e'(o), sew_e'(w), rand64(), rand64());
      end
    end
    // slice carry, element wrap, shifts of negative elements
    for (int w = 0; w < 3; w++) begin
      push_one(op_add, sew_e'(w), 64'hffff_ffff_ffff_ffff, 64'h0101_0101_0101_0101);
      push_one(op_sub, sew_e'(w), 64'h0000_0000_0000_0000, 64'h0101_0101_0101_0101);
      push_one(op_srl, sew_e'(w), 64'h8f80_f0f1_8000_9234, 64'h2d2d_2d2d_2d2d_2d2d);
      push_one(op_sra, sew_e'(w), 64'h8f80_f0f1_8000_9234, 64'h2d2d_2d2d_2d2d_2d2d);
    end

    // drain, then fill queue and every lane with ready low
    push_valid = 1'b0;
    ready_mode = 2;
    while (recv_count != push_count) @(negedge clk);
    ready_mode = 1;
    @(negedge clk);
    for (int k = 0; k < N_FILL; k++) begin
      if (k == N_PRE) begin
        // one cycle of ready on lane 0 pops the queued entries into every lane
        push_valid = 1'b0;
        @(posedge clk);
        ready_mode = 3;
        @(posedge clk);
        ready_mode = 1;
        @(negedge clk);
      end
      assert (push_ready) else begin
        $display("** Error at %0t: push_ready expected 1 actual %b after %0d pushes",
                 $time, push_ready, k);
        stop_on_error();
      end
      push_random();
    end
    push_valid = 1'b0;
    repeat (6) begin
      assert (!push_ready) else begin
        $display("** Error at %0t: push_ready expected 0 actual %b", $time, push_ready);
        stop_on_error();
      end
      @(negedge clk);
    end

    // random traffic with random back-pressure
    ready_mode = 0;
    for (int k = 0; k < N_RAND; k++) begin
      if (($random(seed) & 7) == 0) begin
        push_valid = 1'b0;
        @(negedge clk);
      end
      push_random();
    end
    push_valid = 1'b0;
    ready_mode = 2;
    while (recv_count != push_count) @(negedge clk);
    repeat (2) @(negedge clk);

    if (recv_count == N_PUSH && busy == '0 && result_valid == '0) begin
      $display("TEST PASS");
    end else begin
      $display("run ended with %0d of %0d results and tags %h still outstanding",
               recv_count, N_PUSH, busy);
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
